// File: all.f
common/dpa_pkg.sv
header_loader/header_loader.sv
logic/album_sequencer.sv
copy_engine/copy_engine.sv
logic/im_port_arbiter.sv
logic/dpa_album_top.sv
testbench/im_model.sv
testbench/tb_dpa_album.sv

// File: common/dpa_pkg.sv
// photo album shared types
`default_nettype none

package dpa_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    typedef logic [19:0] im_addr_t;    // image memory word address
    typedef logic [23:0] pixel_t;      // rgb pixel or header word
    typedef logic [1:0]  photo_idx_t;  // photo index, up to 4 photos

    // one image memory access, 45 bits
    typedef struct packed {
        im_addr_t addr;   // word address
        logic     wen_n;  // low for write
        pixel_t   data;   // write data
    } im_req_t;

    // album configuration from header words 0 and 1
    typedef struct packed {
        im_addr_t   fb_base;     // frame buffer start
        photo_idx_t last_photo;  // index of last photo
    } album_cfg_t;

    // ------------------------------------------------------------------
    // sequencer phases
    // ------------------------------------------------------------------
    typedef enum logic [1:0] {
        SETUP,      // waiting for header
        PHOTO_SET,  // fetching photo base address
        COPY,       // photo copy running
        HOLD        // showing photo until frame ends
    } album_state_t;

    // ------------------------------------------------------------------
    // header layout
    // ------------------------------------------------------------------
    localparam im_addr_t HDR_FB_ADDR    = 20'd0;  // frame buffer base
    localparam im_addr_t HDR_PHOTO_NUM  = 20'd1;  // last photo number
    localparam im_addr_t HDR_PHOTO_BASE = 20'd2;  // photo base table start

endpackage

`default_nettype wire

// File: copy_engine/copy_engine.sv
// photo copy engine
`timescale 1ns/10ps
`default_nettype none

module copy_engine #(
    parameter int PHOTO_PIXELS = 65536  // pixels per photo
) (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              copy_start,  // pulse, read 0 goes out now
    input  wire dpa_pkg::im_addr_t photo_base,  // source
    input  wire dpa_pkg::im_addr_t fb_base,     // destination
    input  wire dpa_pkg::pixel_t   im_q,
    output dpa_pkg::im_req_t       cp_req,
    output logic                   cp_active,
    output logic                   copy_done    // with the last write
);
    import dpa_pkg::*;

    localparam int CNT_W = $clog2(PHOTO_PIXELS + 1);
    typedef logic [CNT_W-1:0] pix_cnt_t;
    localparam pix_cnt_t LAST_PIX = pix_cnt_t'(PHOTO_PIXELS - 1);

    pix_cnt_t   rd_cnt;      // next pixel to read
    pix_cnt_t   rd_ofs;      // offset of this cycle's read
    pix_cnt_t   wr_cnt;      // next pixel to write
    logic       rd_run;      // reads left after copy_start
    logic       phase;       // high on odd slots
    logic       rd_slot;     // read issued this cycle
    logic [1:0] rd_pipe;     // read issued 1 and 2 cycles ago
    logic       hold_valid;  // hold has a pixel, write slot
    pixel_t     hold;

    // ------------------------------------------------------------------
    // read side, even slots 0, 2, 4 ...
    // ------------------------------------------------------------------
    assign rd_ofs  = copy_start ? '0 : rd_cnt;
    assign rd_slot = copy_start | (rd_run & ~phase);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_cnt <= '0;
            rd_run <= 1'b0;
            phase  <= 1'b0;
        end else if (rd_slot) begin
            rd_cnt <= rd_ofs + 1'b1;
            rd_run <= (rd_ofs != LAST_PIX);  // stop after last pixel
            phase  <= 1'b1;                  // odd slot follows
        end else begin
            phase  <= 1'b0;
        end
    end

    // ------------------------------------------------------------------
    // return path and write side, odd slots 3, 5, 7 ...
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_pipe    <= '0;
            hold_valid <= 1'b0;
            wr_cnt     <= '0;
        end else begin
            rd_pipe    <= {rd_pipe[0], rd_slot};
            hold_valid <= rd_pipe[1];  // data was on im_q
            if (copy_start)
                wr_cnt <= '0;
            else if (hold_valid)
                wr_cnt <= wr_cnt + 1'b1;
        end
    end

    // pixel holding register
    always_ff @(posedge clk) begin
        if (rd_pipe[1])
            hold <= im_q;
    end

    // request mux, reads and writes never share a slot
    always_comb begin
        if (rd_slot) begin
            cp_req.addr  = photo_base + im_addr_t'(rd_ofs);
            cp_req.wen_n = 1'b1;
        end else begin
            cp_req.addr  = fb_base + im_addr_t'(wr_cnt);
            cp_req.wen_n = ~hold_valid;
        end
        cp_req.data = hold;
    end

    assign cp_active = rd_slot | hold_valid;
    assign copy_done = hold_valid & (wr_cnt == LAST_PIX);

endmodule

`default_nettype wire

// File: header_loader/header_loader.sv
// album header loader
`timescale 1ns/10ps
`default_nettype none

module header_loader (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                fetch_cfg,    // pulse, read words 0 and 1
    input  wire logic                fetch_photo,  // pulse, read one photo base
    input  wire dpa_pkg::photo_idx_t photo_idx,
    input  wire dpa_pkg::pixel_t     im_q,
    output dpa_pkg::im_req_t         ld_req,
    output logic                     ld_active,
    output dpa_pkg::album_cfg_t      cfg,
    output logic                     cfg_valid,    // level, held until reset
    output dpa_pkg::im_addr_t        photo_base,
    output logic                     base_valid    // one cycle pulse
);
    import dpa_pkg::*;

    // tag says which field a returning word belongs to
    typedef logic [1:0] tag_t;
    localparam tag_t TAG_NONE = 2'd0;
    localparam tag_t TAG_FB   = 2'd1;
    localparam tag_t TAG_NUM  = 2'd2;
    localparam tag_t TAG_BASE = 2'd3;

    logic cfg_second;  // second header read pending
    tag_t tag_now;
    tag_t tag_d1;      // request at pins
    tag_t tag_d2;      // data on im_q

    // ------------------------------------------------------------------
    // read requests, issued in the cycle of the fetch pulse
    // ------------------------------------------------------------------
    always_comb begin
        ld_req.wen_n = 1'b1;  // reads only
        ld_req.data  = '0;
        if (cfg_second)
            ld_req.addr = HDR_PHOTO_NUM;
        else if (fetch_photo)
            ld_req.addr = HDR_PHOTO_BASE + im_addr_t'(photo_idx);  // base table entry
        else
            ld_req.addr = HDR_FB_ADDR;
    end

    assign ld_active = fetch_cfg | cfg_second | fetch_photo;

    always_comb begin
        if (cfg_second)
            tag_now = TAG_NUM;
        else if (fetch_photo)
            tag_now = TAG_BASE;
        else if (fetch_cfg)
            tag_now = TAG_FB;
        else
            tag_now = TAG_NONE;
    end

    // ------------------------------------------------------------------
    // tag delay line, matches the two cycle read latency
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_second <= 1'b0;
            tag_d1     <= TAG_NONE;
            tag_d2     <= TAG_NONE;
            cfg_valid  <= 1'b0;
            base_valid <= 1'b0;
        end else begin
            cfg_second <= fetch_cfg;  // word 1 right after word 0
            tag_d1     <= tag_now;
            tag_d2     <= tag_d1;
            base_valid <= (tag_d2 == TAG_BASE);
            if (tag_d2 == TAG_NUM)
                cfg_valid <= 1'b1;    // both words in
        end
    end

    // captured header fields
    always_ff @(posedge clk) begin
        if (tag_d2 == TAG_FB)
            cfg.fb_base <= im_addr_t'(im_q);
        if (tag_d2 == TAG_NUM)
            cfg.last_photo <= photo_idx_t'(im_q);
        if (tag_d2 == TAG_BASE)
            photo_base <= im_addr_t'(im_q);
    end

endmodule

`default_nettype wire

// File: logic/album_sequencer.sv
// album phase sequencer
`timescale 1ns/10ps
`default_nettype none

module album_sequencer #(
    parameter int FRAME_CYCLES = 1000000  // cycles per shown photo
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  cfg_valid,
    input  wire dpa_pkg::album_cfg_t   cfg,
    input  wire logic                  base_valid,
    input  wire logic                  copy_done,
    output logic                       fetch_cfg,
    output logic                       fetch_photo,
    output dpa_pkg::photo_idx_t        photo_idx,
    output logic                       copy_start
);
    import dpa_pkg::*;

    localparam int FRAME_W = $clog2(FRAME_CYCLES);
    typedef logic [FRAME_W-1:0] frame_cnt_t;
    localparam frame_cnt_t FRAME_LAST = frame_cnt_t'(FRAME_CYCLES - 1);

    album_state_t state;
    frame_cnt_t   frame_cnt;     // cycles since last fetch_photo
    logic         cfg_req_done;  // header fetch already sent
    logic         frame_end;

    // last cycle of the photo period
    assign frame_end = (state == HOLD) && (frame_cnt == FRAME_LAST);

    // ------------------------------------------------------------------
    // phase FSM with registered pulses
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= SETUP;
            frame_cnt    <= '0;
            cfg_req_done <= 1'b0;
            fetch_cfg    <= 1'b0;
            fetch_photo  <= 1'b0;
            photo_idx    <= '0;
            copy_start   <= 1'b0;
        end else begin
            fetch_cfg   <= 1'b0;  // pulses default low
            fetch_photo <= 1'b0;
            copy_start  <= 1'b0;
            frame_cnt   <= frame_cnt + 1'b1;

            case (state)
                SETUP: begin
                    if (!cfg_req_done) begin
                        fetch_cfg    <= 1'b1;  // once after reset
                        cfg_req_done <= 1'b1;
                    end
                    if (cfg_valid) begin
                        state       <= PHOTO_SET;
                        fetch_photo <= 1'b1;  // photo 0
                        frame_cnt   <= '0;    // period starts here
                    end
                end
                PHOTO_SET: begin
                    if (base_valid) begin
                        state      <= COPY;
                        copy_start <= 1'b1;
                    end
                end
                COPY: begin
                    if (copy_done)
                        state <= HOLD;
                end
                HOLD: begin
                    if (frame_end) begin
                        state       <= PHOTO_SET;
                        fetch_photo <= 1'b1;
                        frame_cnt   <= '0;
                        // next photo, wrap after the last one
                        if (photo_idx == cfg.last_photo)
                            photo_idx <= '0;
                        else
                            photo_idx <= photo_idx + 1'b1;
                    end
                end
                default: state <= SETUP;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/dpa_album_top.sv
// photo album controller top
`timescale 1ns/10ps
`default_nettype none

// FRAME_CYCLES must exceed the copy time of about 2*PHOTO_PIXELS+8 cycles,
// there is no back-pressure from the image memory
module dpa_album_top #(
    parameter int PHOTO_PIXELS = 65536,   // pixels per photo
    parameter int FRAME_CYCLES = 1000000  // cycles each photo is shown
) (
    input  wire logic              clk,
    input  wire logic              reset,
    output dpa_pkg::im_addr_t      im_a,
    output logic                   im_wen_n,
    output dpa_pkg::pixel_t        im_d,
    input  wire dpa_pkg::pixel_t   im_q
);
    import dpa_pkg::*;

    // memory clients
    im_req_t    ld_req;
    logic       ld_active;
    im_req_t    cp_req;
    logic       cp_active;

    // header handshake
    logic       fetch_cfg;
    logic       fetch_photo;
    photo_idx_t photo_idx;
    album_cfg_t cfg;
    logic       cfg_valid;
    im_addr_t   photo_base;
    logic       base_valid;

    // copy handshake
    logic       copy_start;
    logic       copy_done;

    header_loader u_header_loader (
        .clk         (clk),
        .reset       (reset),
        .fetch_cfg   (fetch_cfg),
        .fetch_photo (fetch_photo),
        .photo_idx   (photo_idx),
        .im_q        (im_q),
        .ld_req      (ld_req),
        .ld_active   (ld_active),
        .cfg         (cfg),
        .cfg_valid   (cfg_valid),
        .photo_base  (photo_base),
        .base_valid  (base_valid)
    );

    album_sequencer #(
        .FRAME_CYCLES (FRAME_CYCLES)
    ) u_album_sequencer (
        .clk         (clk),
        .reset       (reset),
        .cfg_valid   (cfg_valid),
        .cfg         (cfg),
        .base_valid  (base_valid),
        .copy_done   (copy_done),
        .fetch_cfg   (fetch_cfg),
        .fetch_photo (fetch_photo),
        .photo_idx   (photo_idx),
        .copy_start  (copy_start)
    );

    copy_engine #(
        .PHOTO_PIXELS (PHOTO_PIXELS)
    ) u_copy_engine (
        .clk        (clk),
        .reset      (reset),
        .copy_start (copy_start),
        .photo_base (photo_base),
        .fb_base    (cfg.fb_base),
        .im_q       (im_q),
        .cp_req     (cp_req),
        .cp_active  (cp_active),
        .copy_done  (copy_done)
    );

    im_port_arbiter u_im_port_arbiter (
        .clk       (clk),
        .reset     (reset),
        .ld_req    (ld_req),
        .ld_active (ld_active),
        .cp_req    (cp_req),
        .cp_active (cp_active),
        .im_a      (im_a),
        .im_wen_n  (im_wen_n),
        .im_d      (im_d)
    );

endmodule

`default_nettype wire

// File: logic/im_port_arbiter.sv
// image memory port arbiter
`timescale 1ns/10ps
`default_nettype none

module im_port_arbiter (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire dpa_pkg::im_req_t  ld_req,
    input  wire logic              ld_active,
    input  wire dpa_pkg::im_req_t  cp_req,
    input  wire logic              cp_active,
    output dpa_pkg::im_addr_t      im_a,
    output logic                   im_wen_n,
    output dpa_pkg::pixel_t        im_d
);
    import dpa_pkg::*;

    // parked bus, read of word 0 with write off
    localparam im_req_t IDLE_REQ = '{addr: '0, wen_n: 1'b1, data: '0};

    im_req_t sel_req;

    // ------------------------------------------------------------------
    // select, clients are never active together
    // ------------------------------------------------------------------
    always_comb begin
        if (ld_active)
            sel_req = ld_req;
        else if (cp_active)
            sel_req = cp_req;
        else
            sel_req = IDLE_REQ;
    end

    // pin registers
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            im_a     <= '0;
            im_wen_n <= 1'b1;  // no write out of reset
        end else begin
            im_a     <= sel_req.addr;
            im_wen_n <= sel_req.wen_n;
        end
    end

    always_ff @(posedge clk) begin
        im_d <= sel_req.data;  // write data
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the photo album testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/sim_tb_dpa_album

verilator --binary --timing -f all.f --top-module tb_dpa_album -o sim_tb_dpa_album
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    echo "simulation reported failing checks"
    exit 1
fi

echo "simulation finished without failures"
exit 0

// File: testbench/im_model.sv
// behavioral image memory
`timescale 1ns/10ps
`default_nettype none

module im_model #(
    parameter int DEPTH     = 4096,  // words
    parameter int LOG_DEPTH = 1024   // write log entries
) (
    input  wire logic              clk,
    input  wire dpa_pkg::im_addr_t im_a,
    input  wire logic              im_wen_n,   // write when low
    input  wire dpa_pkg::pixel_t   im_d,
    output dpa_pkg::pixel_t        im_q,
    input  wire logic              load_en,    // preload port, used during reset
    input  wire dpa_pkg::im_addr_t load_addr,
    input  wire dpa_pkg::pixel_t   load_data
);
    import dpa_pkg::*;

    localparam int AW = $clog2(DEPTH);

    pixel_t   mem [0:DEPTH-1];

    // ------------------------------------------------------------------
    // write log, read back by the testbench
    // ------------------------------------------------------------------
    im_addr_t wr_addr [0:LOG_DEPTH-1];  // full address, even past DEPTH
    pixel_t   wr_data [0:LOG_DEPTH-1];
    time      wr_time [0:LOG_DEPTH-1];  // posedge of the write
    int       wr_count = 0;             // keeps counting past the log end

    always @(posedge clk) begin
        im_q <= mem[im_a[AW-1:0]];  // data one cycle after the address
        if (load_en) begin
            mem[load_addr[AW-1:0]] <= load_data;
        end else if (!im_wen_n) begin
            mem[im_a[AW-1:0]] <= im_d;
            if (wr_count < LOG_DEPTH) begin
                wr_addr[wr_count] <= im_a;
                wr_data[wr_count] <= im_d;
                wr_time[wr_count] <= $time;
            end
            wr_count <= wr_count + 1;
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_dpa_album.sv
// album controller testbench
`timescale 1ns/10ps
`default_nettype none

module tb_dpa_album;
    import dpa_pkg::*;

    localparam int  PHOTO_PIXELS = 8;
    localparam int  FRAME_CYCLES = 64;
    localparam int  MEM_WORDS    = 4096;
    localparam int  LOG_WORDS    = 1024;
    localparam int  NUM_CASES    = 4;
    localparam time CLK_PERIOD   = 20;
    localparam time FRAME_TIME   = FRAME_CYCLES * CLK_PERIOD;

    // one album layout
    typedef struct packed {
        im_addr_t       fb_base;
        photo_idx_t     last_photo;
        im_addr_t [3:0] bases;       // photo base per index
    } album_case_t;

    logic     clk       = 1'b0;
    logic     reset     = 1'b1;
    im_addr_t im_a;
    logic     im_wen_n;
    pixel_t   im_d;
    pixel_t   im_q;
    logic     load_en   = 1'b0;
    im_addr_t load_addr = '0;
    pixel_t   load_data = '0;

    album_case_t cases [0:NUM_CASES-1];
    string       case_names [0:NUM_CASES-1];
    string       test_name;
    pixel_t      exp_mem [0:MEM_WORDS-1];  // what the image should hold
    im_addr_t    load_q_addr [$];          // words preloaded for this case
    pixel_t      load_q_data [$];
    time         base_time [0:5];          // photo base read per frame
    integer      seed   = 48;
    int          errors = 0;
    int          checks = 0;
    int          passed = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    dpa_album_top #(
        .PHOTO_PIXELS (PHOTO_PIXELS),
        .FRAME_CYCLES (FRAME_CYCLES)
    ) u_dpa_album_top (
        .clk      (clk),
        .reset    (reset),
        .im_a     (im_a),
        .im_wen_n (im_wen_n),
        .im_d     (im_d),
        .im_q     (im_q)
    );

    im_model #(
        .DEPTH     (MEM_WORDS),
        .LOG_DEPTH (LOG_WORDS)
    ) u_im_model (
        .clk       (clk),
        .im_a      (im_a),
        .im_wen_n  (im_wen_n),
        .im_d      (im_d),
        .im_q      (im_q),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    // ------------------------------------------------------------------
    // case table
    // ------------------------------------------------------------------
    task automatic fill_case_table();
        cases[0] = '{fb_base: 20'd100, last_photo: 2'd0,
                     bases: {20'd0, 20'd0, 20'd0, 20'd200}};
        cases[1] = '{fb_base: 20'd300, last_photo: 2'd1,
                     bases: {20'd0, 20'd0, 20'd520, 20'd400}};
        cases[2] = '{fb_base: 20'd1000, last_photo: 2'd3,
                     bases: {20'd4000, 20'd1300, 20'd1200, 20'd1100}};
        // frame buffer and photos packed right behind the header
        cases[3] = '{fb_base: 20'd6, last_photo: 2'd2,
                     bases: {20'd0, 20'd30, 20'd22, 20'd14}};
        case_names[0] = "single photo";
        case_names[1] = "two photos";
        case_names[2] = "four photos wrap";
        case_names[3] = "packed areas";
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error: %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic queue_word(input im_addr_t a, input pixel_t d);
        load_q_addr.push_back(a);
        load_q_data.push_back(d);
        exp_mem[a[11:0]] = d;
    endtask

    // header words, photo base table and random pixels
    task automatic prepare_image(input album_case_t c);
        int p;
        int k;
        load_q_addr.delete();
        load_q_data.delete();
        queue_word(HDR_FB_ADDR, pixel_t'(c.fb_base));
        queue_word(HDR_PHOTO_NUM, pixel_t'(c.last_photo));
        for (p = 0; p <= int'(c.last_photo); p++) begin
            queue_word(HDR_PHOTO_BASE + im_addr_t'(p), pixel_t'(c.bases[p[1:0]]));
            for (k = 0; k < PHOTO_PIXELS; k++) begin
                queue_word(c.bases[p[1:0]] + im_addr_t'(k), pixel_t'($random(seed)));
            end
        end
    endtask

    task automatic load_image();
        int i;
        for (i = 0; i < load_q_addr.size(); i++) begin
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = load_q_addr[i];
            load_data = load_q_data[i];
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    // ------------------------------------------------------------------
    // bounded waits
    // ------------------------------------------------------------------
    task automatic wait_header_reads(output bit ok);
        int n;
        ok = 1'b0;
        for (n = 1; n <= 16 && !ok; n++) begin
            @(negedge clk);
            check_value({test_name, " write idle before header"}, 32'd1, 32'(im_wen_n));
            if (im_a == HDR_PHOTO_NUM) begin
                check_value({test_name, " header read 1 cycle"}, 32'd3, 32'(n));
                ok = 1'b1;
            end else begin
                check_value({test_name, " header read 0 address"}, 32'(HDR_FB_ADDR), 32'(im_a));
            end
        end
        if (!ok) begin
            errors++;
            $display("timeout: %s, the header reads did not show up", test_name);
        end
    endtask

    // base table lives at words 2 to 5, nothing else is read there
    task automatic wait_base_read(input int limit, output time t, output int idx,
                                  output bit ok);
        int n;
        ok  = 1'b0;
        t   = 0;
        idx = 0;
        for (n = 0; n < limit && !ok; n++) begin
            @(negedge clk);
            if (im_wen_n && im_a >= HDR_PHOTO_BASE && im_a < HDR_PHOTO_BASE + 20'd4) begin
                t   = $time;
                idx = int'(im_a - HDR_PHOTO_BASE);
                ok  = 1'b1;
            end
        end
        if (!ok) begin
            errors++;
            $display("timeout: %s, no photo base read within %0d cycles", test_name, limit);
        end
    endtask

    task automatic wait_write_count(input int target, input int limit, output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < limit && !ok; n++) begin
            @(negedge clk);
            ok = (u_im_model.wr_count >= target);
        end
        if (!ok) begin
            errors++;
            $display("timeout: %s, the last photo copy never finished", test_name);
        end
    endtask

    // ------------------------------------------------------------------
    // result checks
    // ------------------------------------------------------------------
    task automatic check_writes(input album_case_t c, input int log_start, input int n_frames);
        int         w;
        int         li;
        int         f;
        int         k;
        int         outside;
        photo_idx_t p;
        im_addr_t   a;
        im_addr_t   src;
        time        t;
        outside = 0;
        if (log_start + n_frames * PHOTO_PIXELS > LOG_WORDS) begin
            errors++;
            $display("%s: the memory write log is full, writes not checked", test_name);
            return;
        end
        for (w = 0; w < n_frames * PHOTO_PIXELS; w++) begin
            li  = log_start + w;
            f   = w / PHOTO_PIXELS;
            k   = w % PHOTO_PIXELS;
            p   = photo_idx_t'(f % (int'(c.last_photo) + 1));  // wraps after last photo
            a   = u_im_model.wr_addr[li];
            t   = u_im_model.wr_time[li];
            src = c.bases[p] + im_addr_t'(k);
            if (a < c.fb_base || a >= c.fb_base + im_addr_t'(PHOTO_PIXELS))
                outside++;
            check_value($sformatf("%s frame %0d write %0d address", test_name, f, k),
                        32'(c.fb_base + im_addr_t'(k)), 32'(a));
            check_value($sformatf("%s frame %0d write %0d data", test_name, f, k),
                        32'(exp_mem[src[11:0]]), 32'(u_im_model.wr_data[li]));
            check_value($sformatf("%s frame %0d write %0d in frame", test_name, f, k), 32'd1,
                        32'(t > base_time[f] && t < base_time[f] + FRAME_TIME));
        end
        check_value({test_name, " writes outside frame buffer"}, 32'd0, 32'(outside));
    endtask

    // header and photo words must survive the copies
    task automatic check_image();
        int       i;
        im_addr_t a;
        for (i = 0; i < load_q_addr.size(); i++) begin
            a = load_q_addr[i];
            check_value($sformatf("%s image word %0h", test_name, a),
                        32'(load_q_data[i]), 32'(u_im_model.mem[a[11:0]]));
        end
    endtask

    task automatic run_case(input int ci);
        album_case_t c;
        int          n_frames;
        int          log_start;
        int          f;
        int          idx;
        int          err_start;
        time         t_read;
        bit          ok;
        c         = cases[ci];
        test_name = case_names[ci];
        err_start = errors;
        n_frames  = int'(c.last_photo) + 2;  // one wrap back to photo 0
        @(negedge clk);
        reset = 1'b1;
        prepare_image(c);
        load_image();
        repeat (3) @(negedge clk);
        log_start = u_im_model.wr_count;
        reset     = 1'b0;
        wait_header_reads(ok);
        for (f = 0; f < n_frames && ok; f++) begin
            wait_base_read(FRAME_CYCLES + 16, t_read, idx, ok);
            if (ok) begin
                check_value({test_name, " photo order"},
                            32'(f % (int'(c.last_photo) + 1)), 32'(idx));
                if (f > 0)
                    check_value({test_name, " frame period"}, 32'(FRAME_CYCLES),
                                32'((t_read - base_time[f-1]) / CLK_PERIOD));
                base_time[f] = t_read;
            end
        end
        if (ok)
            wait_write_count(log_start + n_frames * PHOTO_PIXELS, FRAME_CYCLES, ok);
        if (ok) begin
            repeat (4) @(negedge clk);  // catch stray extra writes
            check_value({test_name, " write count"}, 32'(n_frames * PHOTO_PIXELS),
                        32'(u_im_model.wr_count - log_start));
            check_writes(c, log_start, n_frames);
            check_image();
        end
        if (errors == err_start)
            passed++;
        $display("test %0d %s: %s, %0d errors", ci, test_name,
                 (errors == err_start) ? "pass" : "fail", errors - err_start);
    endtask

    initial begin
        int ci;
        fill_case_table();
        for (ci = 0; ci < NUM_CASES; ci++) begin
            run_case(ci);
        end
        $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                 NUM_CASES, passed, NUM_CASES - passed, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
